// File: verilog/c64_mem_pkg.sv
// ====================
// C64 memory-map types, PRG header size
// and the BASIC zero-page pointer table
// ====================
package c64_mem_pkg;

	typedef logic [15:0] c64_addr_t;
	typedef logic [7:0]  c64_byte_t;

	// Which captured address half a pointer write carries
	typedef enum logic [1:0] {
		SEL_START_LO,
		SEL_START_HI,
		SEL_END_LO,
		SEL_END_HI
	} ptr_sel_e;

	typedef struct packed {
		c64_addr_t zp_addr;
		ptr_sel_e  sel;
	} ptr_entry_t;

	// Little-endian load address in front of the data
	localparam int HDR_BYTES = 2;
	localparam int PTR_COUNT = 12;

	// TXTTAB, VARTAB, ARYTAB, STREND, then SAL and EAL of the kernal
	localparam ptr_entry_t PTR_ADDR [PTR_COUNT] = '{
		'{16'h002B, SEL_START_LO}, '{16'h002C, SEL_START_HI},
		'{16'h002D, SEL_END_LO},   '{16'h002E, SEL_END_HI},
		'{16'h002F, SEL_END_LO},   '{16'h0030, SEL_END_HI},
		'{16'h0031, SEL_END_LO},   '{16'h0032, SEL_END_HI},
		'{16'h00AC, SEL_START_LO}, '{16'h00AD, SEL_START_HI},
		'{16'h00AE, SEL_END_LO},   '{16'h00AF, SEL_END_HI}
	};

endpackage

// File: verilog/wb_bus_pkg.sv
// ====================
// Wishbone bus widths and the write
// request carried from parser to master
// ====================
package wb_bus_pkg;

	// Byte-wide bus over the full 64 KiB map
	localparam int WB_ADR_W = 16;
	localparam int WB_DAT_W = 8;

	// Address in the upper bits, data byte in the lower bits
	typedef logic [WB_ADR_W+WB_DAT_W-1:0] wr_req_t;

endpackage

// File: verilog/prg_stream_parser.sv
// ====================
// PRG stream parser, turns the download into
// data writes and zero-page pointer patches
// ====================
module prg_stream_parser (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  c64_mem_pkg::c64_byte_t dl_data_i,
	input  logic                   full_i,
	output logic                   dl_wait_o,
	output logic                   push_o,
	output wb_bus_pkg::wr_req_t    push_data_o,
	output logic                   patch_done_o
);

	typedef enum logic [1:0] {
		P_IDLE,
		P_HEADER,
		P_DATA,
		P_PATCH
	} parse_state_e;

	localparam logic [1:0] HDR_LAST = 2'(c64_mem_pkg::HDR_BYTES - 1);
	localparam logic [3:0] PTR_END  = 4'(c64_mem_pkg::PTR_COUNT);

	parse_state_e               state;
	logic [1:0]                 hdr_cnt;
	logic [1:0]                 hdr_idx;
	logic [3:0]                 ptr_idx;
	c64_mem_pkg::c64_addr_t     start_addr;
	c64_mem_pkg::c64_addr_t     end_addr;
	logic                       pend_valid;
	wb_bus_pkg::wr_req_t        pend_data;
	c64_mem_pkg::ptr_entry_t    ptr_entry;
	c64_mem_pkg::c64_byte_t     patch_byte;
	logic                       hdr_wr;
	logic                       data_wr;
	logic                       load_patch;

	// One pending request, pushed as soon as the FIFO has room
	assign push_o      = pend_valid & ~full_i;
	assign dl_wait_o   = pend_valid & full_i;
	assign push_data_o = pend_data;

	// A byte may arrive in the same cycle that dl_active_i rises
	assign hdr_idx = (state == P_HEADER) ? hdr_cnt : 2'd0;
	assign hdr_wr  = dl_active_i & dl_wr_i & ((state == P_IDLE) | (state == P_HEADER));
	assign data_wr = dl_active_i & dl_wr_i & (state == P_DATA);

	// ====================
	// Pointer table walk
	// ====================
	assign ptr_entry = c64_mem_pkg::PTR_ADDR[ptr_idx];

	always_comb begin
		case (ptr_entry.sel)
			c64_mem_pkg::SEL_START_LO: patch_byte = start_addr[7:0];
			c64_mem_pkg::SEL_START_HI: patch_byte = start_addr[15:8];
			c64_mem_pkg::SEL_END_LO:   patch_byte = end_addr[7:0];
			default:                   patch_byte = end_addr[15:8];
		endcase
	end

	// First entry goes out right at the end of the stream
	assign load_patch = ~dl_wait_o & (ptr_idx != PTR_END) &
		((state == P_PATCH) | (((state == P_HEADER) | (state == P_DATA)) & ~dl_active_i));

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state        <= P_IDLE;
			hdr_cnt      <= 2'd0;
			ptr_idx      <= 4'd0;
			pend_valid   <= 1'b0;
			patch_done_o <= 1'b0;
		end else begin
			if (push_o)
				pend_valid <= 1'b0;
			case (state)
				P_IDLE, P_HEADER: begin
					if (dl_active_i) begin
						state <= P_HEADER;
						if (state == P_IDLE) begin
							patch_done_o <= 1'b0;
							ptr_idx      <= 4'd0;
							hdr_cnt      <= 2'd0;
						end
						if (dl_wr_i) begin
							hdr_cnt <= hdr_idx + 2'd1;
							if (hdr_idx == HDR_LAST)
								state <= P_DATA;
						end
					end else if (state == P_HEADER) begin
						// Truncated header, patch with what was captured
						state <= P_PATCH;
					end
				end
				P_DATA: begin
					if (!dl_active_i)
						state <= P_PATCH;
					else if (dl_wr_i)
						pend_valid <= 1'b1;
				end
				P_PATCH: begin
					if (ptr_idx == PTR_END && !dl_wait_o) begin
						patch_done_o <= 1'b1;
						state        <= P_IDLE;
					end
				end
				default: state <= P_IDLE;
			endcase
			if (load_patch) begin
				pend_valid <= 1'b1;
				ptr_idx    <= ptr_idx + 4'd1;
			end
		end
	end

	// Address capture and request payload
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			if (hdr_idx == 2'd0) begin
				start_addr[7:0] <= dl_data_i;
				end_addr[7:0]   <= dl_data_i;
			end else begin
				start_addr[15:8] <= dl_data_i;
				end_addr[15:8]   <= dl_data_i;
			end
		end
		if (data_wr) begin
			pend_data <= {end_addr, dl_data_i};
			end_addr  <= end_addr + 16'd1;
		end
		if (load_patch)
			pend_data <= {ptr_entry.zp_addr, patch_byte};
	end

endmodule

// File: verilog/write_req_fifo.sv
// ====================
// Synchronous FIFO of pending write requests
// ====================
module write_req_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                clk_sys,
	input  logic                reset_n,
	input  logic                push_i,
	input  wb_bus_pkg::wr_req_t push_data_i,
	input  logic                pop_i,
	output logic                full_o,
	output logic                empty_o,
	output wb_bus_pkg::wr_req_t head_data_o
);

	// Depth is a power of two, pointers carry one wrap bit
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	wb_bus_pkg::wr_req_t mem [FIFO_DEPTH];
	logic [PTR_W:0]      wr_ptr;
	logic [PTR_W:0]      rd_ptr;
	logic                do_push;
	logic                do_pop;

	// Same slot with different wrap bits means full
	assign full_o  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
	assign empty_o = (wr_ptr == rd_ptr);

	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & ~empty_o;

	// Head is visible without a read strobe
	assign head_data_o = mem[rd_ptr[PTR_W-1:0]];

	// ====================
	// Pointers
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk_sys) begin
		if (do_push)
			mem[wr_ptr[PTR_W-1:0]] <= push_data_i;
	end

endmodule

// File: verilog/wb_write_master.sv
// ====================
// Wishbone classic write master draining the
// request FIFO, plus the end-of-load pulse
// ====================
module wb_write_master (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   empty_i,
	input  wb_bus_pkg::wr_req_t    head_data_i,
	input  logic                   patch_done_i,
	input  logic                   wb_ack_i,
	output logic                   pop_o,
	output logic                   wb_cyc_o,
	output logic                   wb_stb_o,
	output logic                   wb_we_o,
	output c64_mem_pkg::c64_addr_t wb_adr_o,
	output c64_mem_pkg::c64_byte_t wb_dat_o,
	output logic                   done_o
);

	typedef enum logic {
		M_IDLE,
		M_BUS
	} master_state_e;

	master_state_e state;
	logic          done_fired;

	// Head is taken in the cycle it is latched onto the bus
	assign pop_o = (state == M_IDLE) & ~empty_i;

	// Write-only master, one transfer per cycle
	assign wb_cyc_o = (state == M_BUS);
	assign wb_stb_o = (state == M_BUS);
	assign wb_we_o  = (state == M_BUS);

	// Patch stream drained and bus quiet
	assign done_o = patch_done_i & empty_i & (state == M_IDLE) & ~done_fired;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state      <= M_IDLE;
			done_fired <= 1'b0;
		end else begin
			case (state)
				M_IDLE: begin
					if (!empty_i)
						state <= M_BUS;
				end
				M_BUS: begin
					// cyc and stb drop the cycle after ack
					if (wb_ack_i)
						state <= M_IDLE;
				end
				default: state <= M_IDLE;
			endcase
			// Rearmed when the parser starts a new download
			if (done_o)
				done_fired <= 1'b1;
			else if (!patch_done_i)
				done_fired <= 1'b0;
		end
	end

	// Address and data held for the whole bus cycle
	always_ff @(posedge clk_sys) begin
		if (pop_o) begin
			wb_adr_o <= head_data_i[wb_bus_pkg::WB_DAT_W +: wb_bus_pkg::WB_ADR_W];
			wb_dat_o <= head_data_i[wb_bus_pkg::WB_DAT_W-1:0];
		end
	end

endmodule

// File: verilog/prg_injector.sv
// ====================
// PRG injector top, parser to FIFO to Wishbone
// ====================
module prg_injector #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  c64_mem_pkg::c64_byte_t dl_data_i,
	input  logic                   wb_ack_i,
	output logic                   dl_wait_o,
	output logic                   wb_cyc_o,
	output logic                   wb_stb_o,
	output logic                   wb_we_o,
	output c64_mem_pkg::c64_addr_t wb_adr_o,
	output c64_mem_pkg::c64_byte_t wb_dat_o,
	output logic                   done_o
);

	logic                push;
	wb_bus_pkg::wr_req_t push_data;
	logic                full;
	logic                empty;
	wb_bus_pkg::wr_req_t head_data;
	logic                pop;
	logic                patch_done;

	prg_stream_parser u_parser (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.dl_active_i  (dl_active_i),
		.dl_wr_i      (dl_wr_i),
		.dl_data_i    (dl_data_i),
		.full_i       (full),
		.dl_wait_o    (dl_wait_o),
		.push_o       (push),
		.push_data_o  (push_data),
		.patch_done_o (patch_done)
	);

	write_req_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.push_i      (push),
		.push_data_i (push_data),
		.pop_i       (pop),
		.full_o      (full),
		.empty_o     (empty),
		.head_data_o (head_data)
	);

	wb_write_master u_master (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.empty_i      (empty),
		.head_data_i  (head_data),
		.patch_done_i (patch_done),
		.wb_ack_i     (wb_ack_i),
		.pop_o        (pop),
		.wb_cyc_o     (wb_cyc_o),
		.wb_stb_o     (wb_stb_o),
		.wb_we_o      (wb_we_o),
		.wb_adr_o     (wb_adr_o),
		.wb_dat_o     (wb_dat_o),
		.done_o       (done_o)
	);

endmodule

// File: sim/prg_injector_props.sv
// ====================
// Wishbone and download handshake assertions
// ====================
module prg_injector_props (
	input logic                   clk_sys,
	input logic                   reset_n,
	input logic                   cyc_i,
	input logic                   stb_i,
	input logic                   ack_i,
	input c64_mem_pkg::c64_addr_t adr_i,
	input c64_mem_pkg::c64_byte_t dat_i,
	input logic                   dl_wr_i,
	input logic                   dl_wait_i,
	input logic                   done_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// Strobe only inside an open cycle
	stb_in_cyc: assert property (@(posedge clk_sys) disable iff (!reset_n)
		stb_i |-> cyc_i)
		else $error("wb_stb_o high without wb_cyc_o");

	// Address and data held until the slave answers
	adr_dat_stable: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(stb_i && !ack_i) |=> ($stable(adr_i) && $stable(dat_i)))
		else $error("wb_adr_o or wb_dat_o changed while waiting for ack");

	// Host must hold its byte while the parser is stalled
	no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!(dl_wr_i && dl_wait_i))
		else $error("dl_wr_i strobed while dl_wait_o was high");

	done_single: assert property (@(posedge clk_sys) disable iff (!reset_n)
		done_i |=> !done_i)
		else $error("done_o high for two cycles in a row");

endmodule

// File: sim/prg_injector_tb.sv
// ====================
// Testbench with clock, reset, RAM slave, LFSR,
// directed load tests and watchdog
// ====================
module prg_injector_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int WORST_ACK  = 23;
	localparam int PTR_WRITES = 12;
	// Header plus data bytes of all four loads
	localparam int FILE_BYTES = (20 + 2) + (40 + 2) + 2 + (12 + 2);
	localparam int BUS_WRITES = FILE_BYTES - 8 + 4 * PTR_WRITES;
	localparam int WATCHDOG_NS =
		(FILE_BYTES + BUS_WRITES) * (WORST_ACK + 4) * CLK_PERIOD * 2 + 200;

	logic        clk_sys;
	logic        reset_n;
	logic        dl_active_i;
	logic        dl_wr_i;
	logic [7:0]  dl_data_i;
	logic        wb_ack_i;
	logic        dl_wait_o;
	logic        wb_cyc_o;
	logic        wb_stb_o;
	logic        wb_we_o;
	logic [15:0] wb_adr_o;
	logic [7:0]  wb_dat_o;
	logic        done_o;

	logic [7:0]  ram [65536];
	logic [15:0] write_log [$];
	logic [7:0]  file_data [$];
	logic [15:0] lfsr_state = 16'd63;
	logic        long_acks = 1'b0;
	logic        wait_seen = 1'b0;
	int          done_count = 0;

	// BASIC and kernal pointer bytes in ascending order
	logic [15:0] zp_ptrs [PTR_WRITES] = '{
		16'h002B, 16'h002C, 16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h00AC, 16'h00AD, 16'h00AE, 16'h00AF
	};

	prg_injector #(
		.FIFO_DEPTH (4)
	) uut (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_data_i   (dl_data_i),
		.wb_ack_i    (wb_ack_i),
		.dl_wait_o   (dl_wait_o),
		.wb_cyc_o    (wb_cyc_o),
		.wb_stb_o    (wb_stb_o),
		.wb_we_o     (wb_we_o),
		.wb_adr_o    (wb_adr_o),
		.wb_dat_o    (wb_dat_o),
		.done_o      (done_o)
	);

	bind prg_injector prg_injector_props u_props (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.cyc_i     (wb_cyc_o),
		.stb_i     (wb_stb_o),
		.ack_i     (wb_ack_i),
		.adr_i     (wb_adr_o),
		.dat_i     (wb_dat_o),
		.dl_wr_i   (dl_wr_i),
		.dl_wait_i (dl_wait_o),
		.done_i    (done_o)
	);

	// ====================
	// Helpers
	// ====================
	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else
			report_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	// Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic next_random_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 16'hB400;
		return out;
	endfunction

	function automatic int random_bits(input int width);
		int value;
		value = 0;
		for (int i = 0; i < width; i++)
			value = (value << 1) | int'(next_random_bit());
		return value;
	endfunction

	function automatic logic [7:0] fill_byte(input logic [15:0] a);
		return a[15:8] ^ {a[6:0], a[7]} ^ 8'hA5;
	endfunction

	function automatic logic [7:0] expected_ptr_byte(input logic [15:0] zp,
		input logic [15:0] start_a, input logic [15:0] end_a);
		case (zp)
			16'h002B, 16'h00AC: return start_a[7:0];
			16'h002C, 16'h00AD: return start_a[15:8];
			16'h002D, 16'h002F, 16'h0031, 16'h00AE: return end_a[7:0];
			default: return end_a[15:8];
		endcase
	endfunction

	// ====================
	// Clock, RAM slave, monitors
	// ====================
	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin : ram_model
		int delay;
		for (int a = 0; a < 65536; a++)
			ram[a] = fill_byte(16'(a));
		wb_ack_i = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			wb_ack_i = 1'b0;
			if (wb_cyc_o && wb_stb_o) begin
				if (!wb_we_o)
					report_error("Bus cycle opened without wb_we_o");
				delay = long_acks ? 8 + random_bits(4) : random_bits(2);
				repeat (delay) begin
					@(posedge clk_sys);
					#1;
				end
				ram[wb_adr_o] = wb_dat_o;
				write_log.push_back(wb_adr_o);
				wb_ack_i = 1'b1;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (reset_n && done_o)
			done_count++;
		if (reset_n && dl_wait_o)
			wait_seen = 1'b1;
	end

	initial begin
		#(WATCHDOG_NS);
		report_error("Watchdog expired before the tests finished");
	end

	// ====================
	// Host side of the download port
	// ====================
	task automatic send_byte(input logic [7:0] b);
		while (dl_wait_o) begin
			@(posedge clk_sys);
			#1;
		end
		dl_wr_i   = 1'b1;
		dl_data_i = b;
		@(posedge clk_sys);
		#1;
		dl_wr_i = 1'b0;
	endtask

	task automatic wait_done(input int limit);
		int start_count;
		int cycles;
		start_count = done_count;
		cycles = 0;
		while (done_count == start_count) begin
			@(posedge clk_sys);
			#1;
			cycles++;
			if (cycles > limit)
				report_error("Timed out waiting for done_o");
		end
		// Give a second pulse the chance to show up
		repeat (8) begin
			@(posedge clk_sys);
			#1;
		end
		check_value("done_o pulses", 16'(done_count - start_count), 16'd1);
	endtask

	task automatic make_file(input int n);
		file_data.delete();
		repeat (n)
			file_data.push_back(8'(random_bits(8)));
	endtask

	task automatic load_file(input logic [15:0] load_addr);
		write_log.delete();
		dl_active_i = 1'b1;
		@(posedge clk_sys);
		#1;
		send_byte(load_addr[7:0]);
		send_byte(load_addr[15:8]);
		foreach (file_data[i])
			send_byte(file_data[i]);
		dl_active_i = 1'b0;
		dl_data_i   = 8'h00;
		wait_done((file_data.size() + 16) * (WORST_ACK + 4) * 2);
	endtask

	// Data in order at the load address followed by the twelve pointer patches
	task automatic check_load(input logic [15:0] load_addr);
		logic [15:0] end_addr;
		logic [15:0] a;
		int n;
		n = file_data.size();
		end_addr = load_addr + 16'(n);
		check_value("bus write count", 16'(write_log.size()), 16'(n + PTR_WRITES));
		for (int i = 0; i < n; i++) begin
			a = load_addr + 16'(i);
			check_value("wb_adr_o", write_log[i], a);
			check_value($sformatf("ram[%h]", a), 16'(ram[a]), 16'(file_data[i]));
		end
		for (int j = 0; j < PTR_WRITES; j++) begin
			a = zp_ptrs[j];
			check_value("wb_adr_o", write_log[n + j], a);
			check_value($sformatf("ram[%h]", a), 16'(ram[a]),
				16'(expected_ptr_byte(a, load_addr, end_addr)));
		end
	endtask

	// ====================
	// Directed tests
	// ====================
	task automatic basic_load();
		make_file(20);
		load_file(16'h0801);
		check_load(16'h0801);
		check_value("ram[0800]", 16'(ram[16'h0800]), 16'(fill_byte(16'h0800)));
		check_value("ram[0815]", 16'(ram[16'h0815]), 16'(fill_byte(16'h0815)));
	endtask

	task automatic slow_ack_load();
		long_acks = 1'b1;
		wait_seen = 1'b0;
		make_file(40);
		load_file(16'h2000);
		check_load(16'h2000);
		assert (wait_seen) else
			report_error("dl_wait_o never rose during the slow-ack load");
		long_acks = 1'b0;
	endtask

	task automatic header_only_load();
		make_file(0);
		load_file(16'hC000);
		check_load(16'hC000);
	endtask

	task automatic second_download();
		make_file(12);
		load_file(16'h1000);
		check_load(16'h1000);
	endtask

	initial begin
		reset_n     = 1'b0;
		dl_active_i = 1'b0;
		dl_wr_i     = 1'b0;
		dl_data_i   = 8'h00;
		repeat (5) @(posedge clk_sys);
		#1;
		check_value("dl_wait_o", 16'(dl_wait_o), 16'h0);
		check_value("wb_cyc_o", 16'(wb_cyc_o), 16'h0);
		check_value("wb_stb_o", 16'(wb_stb_o), 16'h0);
		check_value("wb_we_o", 16'(wb_we_o), 16'h0);
		check_value("done_o", 16'(done_o), 16'h0);
		reset_n = 1'b1;
		basic_load();
		slow_ack_load();
		header_only_load();
		second_download();
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: prg_injector.f
verilog/c64_mem_pkg.sv
verilog/wb_bus_pkg.sv
verilog/prg_stream_parser.sv
verilog/write_req_fifo.sv
verilog/wb_write_master.sv
verilog/prg_injector.sv
sim/prg_injector_props.sv
sim/prg_injector_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the PRG injector testbench with Verilator and runs it.
# The exit status is the simulator's, so a failed check fails the script.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/100ps \
	--top-module prg_injector_tb \
	-Mdir obj_dir \
	-f prg_injector.f &&
./obj_dir/Vprg_injector_tb || {
	echo "Simulation failed" >&2
	exit 1
}
